/* verilog.f */
rtl/noc_cfg_pkg.sv
rtl/flit_pkg.sv
rtl/flit_info_if.sv
rtl/ssa_grant_if.sv
rtl/flit_hdr_decoder.sv
rtl/ssa_port_ctrl.sv
rtl/ssa_outport_map.sv
rtl/ss_allocator.sv
verif/ss_allocator_checker.sv
verif/tb_ss_allocator.sv

/* verif/tb_ss_allocator.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ss_allocator;

    localparam int NP = noc_cfg_pkg::NUM_PORTS;
    localparam int RAND_CYCLES = 2000;
    localparam int MAX_CYCLES = 2100;  // reset plus directed plus random cycles with margin

    logic clk, rst_i;
    flit_pkg::flit_t flit_i [NP];
    logic [NP-1:0] flit_wr_i, any_ovc_granted_i, any_ivc_sw_granted_i, ssa_flit_wr_o;
    noc_cfg_pkg::vc_mask_t ovc_avail_i [NP], ovc_full_i [NP], ivc_req_i [NP];
    noc_cfg_pkg::vc_mask_t ovc_is_assigned_i [NP];
    flit_pkg::vc_grant_t assigned_ovc_i [NP], ivc_granted_ovc_o [NP], exp_gov [NP];
    noc_cfg_pkg::port_e buf_dest_i [NP][noc_cfg_pkg::NUM_VCS];
    noc_cfg_pkg::vc_mask_t ovc_is_allocated_o [NP], ovc_is_released_o [NP];
    noc_cfg_pkg::vc_mask_t ivc_sw_grant_o [NP], ivc_ovc_grant_o [NP], ivc_reset_o [NP];
    noc_cfg_pkg::vc_mask_t buff_space_decreased_o [NP];
    noc_cfg_pkg::vc_mask_t ivc_single_flit_o [NP], ovc_single_flit_o [NP];
    noc_cfg_pkg::vc_mask_t exp_alloc [NP], exp_release [NP], exp_sw [NP], exp_ovcg [NP];
    noc_cfg_pkg::vc_mask_t exp_reset [NP], exp_credit [NP], exp_isingle [NP], exp_osingle [NP];
    logic [NP-1:0] exp_any, exp_wr;
    int mask_errs = 0;
    int grant_errs = 0;
    int wr_errs = 0;
    int cycle_cnt = 0;

    ss_allocator ss_allocator_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("ERROR: timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic int straight_of(input int p);
        case (p)
            int'(noc_cfg_pkg::PORT_EAST):  return int'(noc_cfg_pkg::PORT_WEST);
            int'(noc_cfg_pkg::PORT_NORTH): return int'(noc_cfg_pkg::PORT_SOUTH);
            int'(noc_cfg_pkg::PORT_WEST):  return int'(noc_cfg_pkg::PORT_EAST);
            int'(noc_cfg_pkg::PORT_SOUTH): return int'(noc_cfg_pkg::PORT_NORTH);
            default: return p;  // local, no straight path
        endcase
    endfunction

    // each bit high with probability 1/n
    function automatic noc_cfg_pkg::vc_mask_t rare_bits(input int n);
        noc_cfg_pkg::vc_mask_t m;
        for (int v = 0; v < noc_cfg_pkg::NUM_VCS; v++) begin
            m[v] = ($urandom_range(0, n - 1) == 0);
        end
        return m;
    endfunction

    // straight port two times in three, otherwise any port
    function automatic noc_cfg_pkg::port_e biased_dest(input int s);
        if ($urandom_range(0, 2) != 0) begin
            return noc_cfg_pkg::port_e'(s);
        end
        return noc_cfg_pkg::port_e'($urandom_range(0, 4));
    endfunction

    task automatic check_mask(input string name, input noc_cfg_pkg::vc_mask_t got,
                              input noc_cfg_pkg::vc_mask_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            mask_errs++;
        end
    endtask

    task automatic check_grant(input string name, input flit_pkg::vc_grant_t got,
                               input flit_pkg::vc_grant_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            grant_errs++;
        end
    endtask

    task automatic check_wr(input string name, input logic [NP-1:0] got,
                            input logic [NP-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            wr_errs++;
        end
    endtask

    task automatic run_model();
        int s;
        logic ok;
        for (int p = 0; p < NP; p++) begin
            exp_alloc[p] = '0;
            exp_release[p] = '0;
            exp_sw[p] = '0;
            exp_ovcg[p] = '0;
            exp_reset[p] = '0;
            exp_credit[p] = '0;
            exp_isingle[p] = '0;
            exp_osingle[p] = '0;
            exp_gov[p] = '0;
        end
        exp_any = '0;
        for (int p = 0; p < NP; p++) begin
            s = straight_of(p);
            for (int v = 0; v < noc_cfg_pkg::NUM_VCS; v++) begin
                if (ovc_is_assigned_i[p][v]) begin
                    ok = (int'(buf_dest_i[p][v]) == s) && assigned_ovc_i[p][v][v]
                         && !ovc_full_i[s][v];
                end else begin
                    ok = ovc_avail_i[s][v];
                end
                ok = ok && s != p && flit_wr_i[p] && flit_i[p].vc[v] && !ivc_req_i[p][v];
                ok = ok && !any_ovc_granted_i[s] && !any_ivc_sw_granted_i[p];
                ok = ok && !(flit_i[p].hdr && int'(flit_i[p].dest) != s);  // turning header
                if (ok) begin
                    exp_sw[p][v] = 1'b1;
                    exp_credit[s][v] = 1'b1;
                    exp_any[s] = 1'b1;
                    exp_ovcg[p][v] = flit_i[p].hdr;
                    exp_gov[p][v][v] = flit_i[p].hdr;
                    exp_reset[p][v] = flit_i[p].tail;
                    if (flit_i[p].hdr && flit_i[p].tail) begin
                        exp_isingle[p][v] = 1'b1;
                        exp_osingle[s][v] = 1'b1;
                    end else begin
                        exp_alloc[s][v] = flit_i[p].hdr;
                        exp_release[s][v] = flit_i[p].tail;
                    end
                end
            end
        end
    endtask

    // register sees last cycle's grants at this edge
    task automatic next_cycle();
        @(posedge clk);
        exp_wr = rst_i ? '0 : exp_any;
        #1;
    endtask

    task automatic apply_and_check();
        run_model();
        #3;
        for (int p = 0; p < NP; p++) begin
            check_mask($sformatf("ovc_is_allocated_o[%0d]", p), ovc_is_allocated_o[p], exp_alloc[p]);
            check_mask($sformatf("ovc_is_released_o[%0d]", p), ovc_is_released_o[p], exp_release[p]);
            check_mask($sformatf("ivc_sw_grant_o[%0d]", p), ivc_sw_grant_o[p], exp_sw[p]);
            check_mask($sformatf("ivc_ovc_grant_o[%0d]", p), ivc_ovc_grant_o[p], exp_ovcg[p]);
            check_mask($sformatf("ivc_reset_o[%0d]", p), ivc_reset_o[p], exp_reset[p]);
            check_mask($sformatf("buff_space_decreased_o[%0d]", p), buff_space_decreased_o[p],
                       exp_credit[p]);
            check_mask($sformatf("ivc_single_flit_o[%0d]", p), ivc_single_flit_o[p], exp_isingle[p]);
            check_mask($sformatf("ovc_single_flit_o[%0d]", p), ovc_single_flit_o[p], exp_osingle[p]);
            check_grant($sformatf("ivc_granted_ovc_o[%0d]", p), ivc_granted_ovc_o[p], exp_gov[p]);
        end
        check_wr("ssa_flit_wr_o", ssa_flit_wr_o, exp_wr);
    endtask

    task automatic set_idle();
        for (int p = 0; p < NP; p++) begin
            flit_i[p] = '0;
            ovc_avail_i[p] = '1;
            ovc_full_i[p] = '0;
            ivc_req_i[p] = '0;
            ovc_is_assigned_i[p] = '0;
            assigned_ovc_i[p] = '0;
            buf_dest_i[p][0] = noc_cfg_pkg::PORT_LOCAL;
            buf_dest_i[p][1] = noc_cfg_pkg::PORT_LOCAL;
        end
        flit_wr_i = '0;
        any_ovc_granted_i = '0;
        any_ivc_sw_granted_i = '0;
    endtask

    task automatic randomize_inputs();
        int s;
        for (int p = 0; p < NP; p++) begin
            s = straight_of(p);
            flit_i[p] = flit_pkg::flit_t'($urandom);
            flit_i[p].vc = ($urandom_range(0, 1) == 0) ? 2'b01 : 2'b10;
            flit_i[p].dest = biased_dest(s);
            flit_wr_i[p] = ($urandom_range(0, 3) != 0);
            any_ovc_granted_i[p] = ($urandom_range(0, 5) == 0);  // mostly idle
            any_ivc_sw_granted_i[p] = ($urandom_range(0, 5) == 0);
            ovc_avail_i[p] = ~rare_bits(4);
            ovc_full_i[p] = rare_bits(4);
            ivc_req_i[p] = rare_bits(5);
            ovc_is_assigned_i[p] = noc_cfg_pkg::vc_mask_t'($urandom);
            assigned_ovc_i[p] = flit_pkg::vc_grant_t'($urandom);
            for (int v = 0; v < noc_cfg_pkg::NUM_VCS; v++) begin
                buf_dest_i[p][v] = biased_dest(s);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h6643));
        rst_i = 1'b1;
        exp_any = '0;
        exp_wr = '0;
        set_idle();
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            if (i == 7) rst_i = 1'b0;
            apply_and_check();
        end

        // east header heading west with everything idle
        next_cycle();
        set_idle();
        flit_i[1] = '{hdr: 1'b1, tail: 1'b0, vc: 2'b01, dest: noc_cfg_pkg::PORT_WEST, payload: '0};
        flit_wr_i[1] = 1'b1;
        apply_and_check();
        check_mask("ivc_sw_grant_o[1]", ivc_sw_grant_o[1], 2'b01);
        check_mask("ovc_is_allocated_o[3]", ovc_is_allocated_o[3], 2'b01);

        // west port busy while the flit write follows the last grant
        next_cycle();
        any_ovc_granted_i[3] = 1'b1;
        apply_and_check();
        check_mask("ivc_sw_grant_o[1]", ivc_sw_grant_o[1], 2'b00);
        check_wr("ssa_flit_wr_o[3]", ssa_flit_wr_o & 5'b01000, 5'b01000);

        next_cycle();
        any_ovc_granted_i[3] = 1'b0;
        any_ivc_sw_granted_i[1] = 1'b1;
        apply_and_check();

        // tail on assigned, not full vc 1
        next_cycle();
        set_idle();
        flit_i[1] = '{hdr: 1'b0, tail: 1'b1, vc: 2'b10, dest: noc_cfg_pkg::PORT_LOCAL, payload: '0};
        flit_wr_i[1] = 1'b1;
        ovc_is_assigned_i[1] = 2'b10;
        assigned_ovc_i[1] = 4'b1000;
        buf_dest_i[1][1] = noc_cfg_pkg::PORT_WEST;
        apply_and_check();
        check_mask("ovc_is_released_o[3]", ovc_is_released_o[3], 2'b10);

        // single-flit packet
        next_cycle();
        set_idle();
        flit_i[1] = '{hdr: 1'b1, tail: 1'b1, vc: 2'b01, dest: noc_cfg_pkg::PORT_WEST, payload: '0};
        flit_wr_i[1] = 1'b1;
        apply_and_check();
        check_mask("ivc_reset_o[1]", ivc_reset_o[1], 2'b01);

        // local flit, and a turning header on north
        next_cycle();
        set_idle();
        flit_i[0] = '{hdr: 1'b1, tail: 1'b0, vc: 2'b01, dest: noc_cfg_pkg::PORT_LOCAL, payload: '0};
        flit_i[2] = '{hdr: 1'b1, tail: 1'b0, vc: 2'b10, dest: noc_cfg_pkg::PORT_EAST, payload: '0};
        flit_wr_i = 5'b00101;
        apply_and_check();

        repeat (RAND_CYCLES) begin
            next_cycle();
            randomize_inputs();
            apply_and_check();
        end

        $display("errors: mask %0d, granted ovc %0d, flit write %0d, assertions %0d",
                 mask_errs, grant_errs, wr_errs, ss_allocator_inst.u_checker.fail_cnt);
        if (mask_errs + grant_errs + wr_errs + ss_allocator_inst.u_checker.fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/ss_allocator_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module ss_allocator_checker (
    input  logic                    clk,
    input  logic                    rst_i,
    input  noc_cfg_pkg::vc_mask_t   ovc_is_allocated_o     [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::vc_mask_t   ovc_is_released_o      [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::vc_mask_t   ivc_sw_grant_o         [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::vc_mask_t   ivc_ovc_grant_o        [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::vc_mask_t   ivc_reset_o            [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::vc_mask_t   buff_space_decreased_o [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::vc_mask_t   ivc_single_flit_o      [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::vc_mask_t   ovc_single_flit_o      [noc_cfg_pkg::NUM_PORTS],
    input  flit_pkg::vc_grant_t     ivc_granted_ovc_o      [noc_cfg_pkg::NUM_PORTS],
    input  logic [noc_cfg_pkg::NUM_PORTS-1:0] ssa_flit_wr_o
);

    int fail_cnt = 0;  // failed assertion count

    for (genvar p = 0; p < noc_cfg_pkg::NUM_PORTS; p++) begin : g_port
        localparam int SP = int'(noc_cfg_pkg::STRAIGHT_PORT[p]);

        // single-flit packets never allocate the ovc
        a_alloc_single: assert property (@(posedge clk) disable iff (rst_i)
            (ovc_is_allocated_o[p] & ovc_single_flit_o[p]) == '0)
            else begin
                $error("ovc allocated and single flit on port %0d", p);
                fail_cnt++;
            end

        if (SP != p) begin : g_straight
            a_wr_follow: assert property (@(posedge clk) disable iff (rst_i)
                ##1 ssa_flit_wr_o[SP] == $past(|ivc_sw_grant_o[p]))
                else begin
                    $error("flit write on port %0d does not follow grant", SP);
                    fail_cnt++;
                end
        end
    end

    // local port has no straight partner
    a_local_zero: assert property (@(posedge clk) disable iff (rst_i)
        ivc_sw_grant_o[0] == '0 && ivc_ovc_grant_o[0] == '0 && ivc_reset_o[0] == '0
        && ivc_single_flit_o[0] == '0 && ivc_granted_ovc_o[0] == '0
        && ovc_is_allocated_o[0] == '0 && ovc_is_released_o[0] == '0
        && buff_space_decreased_o[0] == '0 && ovc_single_flit_o[0] == '0
        && !ssa_flit_wr_o[0])
        else begin
            $error("local port output is not zero");
            fail_cnt++;
        end

endmodule

bind ss_allocator ss_allocator_checker u_checker (.*);

`default_nettype wire

/* rtl/ss_allocator.sv */
`timescale 1ns/1ns
`default_nettype none

module ss_allocator (
    input  logic                    clk,
    input  logic                    rst_i,
    input  flit_pkg::flit_t         flit_i               [noc_cfg_pkg::NUM_PORTS],
    input  logic [noc_cfg_pkg::NUM_PORTS-1:0] flit_wr_i,
    input  logic [noc_cfg_pkg::NUM_PORTS-1:0] any_ovc_granted_i,     // per output port
    input  logic [noc_cfg_pkg::NUM_PORTS-1:0] any_ivc_sw_granted_i,  // per input port
    input  noc_cfg_pkg::vc_mask_t   ovc_avail_i          [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::vc_mask_t   ovc_full_i           [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::vc_mask_t   ivc_req_i            [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::vc_mask_t   ovc_is_assigned_i    [noc_cfg_pkg::NUM_PORTS],
    input  flit_pkg::vc_grant_t     assigned_ovc_i       [noc_cfg_pkg::NUM_PORTS],
    input  noc_cfg_pkg::port_e      buf_dest_i [noc_cfg_pkg::NUM_PORTS][noc_cfg_pkg::NUM_VCS],
    output noc_cfg_pkg::vc_mask_t   ovc_is_allocated_o     [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ovc_is_released_o      [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ivc_sw_grant_o         [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ivc_ovc_grant_o        [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ivc_reset_o            [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   buff_space_decreased_o [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ivc_single_flit_o      [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ovc_single_flit_o      [noc_cfg_pkg::NUM_PORTS],
    output flit_pkg::vc_grant_t     ivc_granted_ovc_o      [noc_cfg_pkg::NUM_PORTS],
    output logic [noc_cfg_pkg::NUM_PORTS-1:0] ssa_flit_wr_o
);

    flit_info_if info_if  [noc_cfg_pkg::NUM_PORTS] ();
    ssa_grant_if grant_if [noc_cfg_pkg::NUM_PORTS] ();

    for (genvar p = 0; p < noc_cfg_pkg::NUM_PORTS; p++) begin : g_port
        localparam int SP = int'(noc_cfg_pkg::STRAIGHT_PORT[p]);

        flit_hdr_decoder u_decoder (
            .flit_i    (flit_i[p]),
            .flit_wr_i (flit_wr_i[p]),
            .info      (info_if[p])
        );

        // busy, avail and full all come from the straight port
        ssa_port_ctrl u_ctrl (
            .in_port_i            (noc_cfg_pkg::port_e'(p)),
            .info                 (info_if[p]),
            .ss_port_busy_i       (any_ovc_granted_i[SP]),
            .in_port_sw_granted_i (any_ivc_sw_granted_i[p]),
            .ovc_avail_i          (ovc_avail_i[SP]),
            .ovc_full_i           (ovc_full_i[SP]),
            .ivc_req_i            (ivc_req_i[p]),
            .ovc_is_assigned_i    (ovc_is_assigned_i[p]),
            .assigned_ovc_i       (assigned_ovc_i[p]),
            .buf_dest_i           (buf_dest_i[p]),
            .grant                (grant_if[p])
        );
    end

    ssa_outport_map u_map (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .grant                  (grant_if),
        .ovc_is_allocated_o     (ovc_is_allocated_o),
        .ovc_is_released_o      (ovc_is_released_o),
        .ivc_sw_grant_o         (ivc_sw_grant_o),
        .ivc_ovc_grant_o        (ivc_ovc_grant_o),
        .ivc_reset_o            (ivc_reset_o),
        .buff_space_decreased_o (buff_space_decreased_o),
        .ivc_single_flit_o      (ivc_single_flit_o),
        .ovc_single_flit_o      (ovc_single_flit_o),
        .ivc_granted_ovc_o      (ivc_granted_ovc_o),
        .ssa_flit_wr_o          (ssa_flit_wr_o)
    );

endmodule

`default_nettype wire

/* rtl/ssa_outport_map.sv */
`timescale 1ns/1ns
`default_nettype none

module ssa_outport_map (
    input  logic                    clk,
    input  logic                    rst_i,
    ssa_grant_if.map                grant [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ovc_is_allocated_o     [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ovc_is_released_o      [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ivc_sw_grant_o         [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ivc_ovc_grant_o        [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ivc_reset_o            [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   buff_space_decreased_o [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ivc_single_flit_o      [noc_cfg_pkg::NUM_PORTS],
    output noc_cfg_pkg::vc_mask_t   ovc_single_flit_o      [noc_cfg_pkg::NUM_PORTS],
    output flit_pkg::vc_grant_t     ivc_granted_ovc_o      [noc_cfg_pkg::NUM_PORTS],
    output logic [noc_cfg_pkg::NUM_PORTS-1:0] ssa_flit_wr_o
);

    // any straight switch grant landing on each output port
    logic [noc_cfg_pkg::NUM_PORTS-1:0] straight_sw_any;

    for (genvar p = 0; p < noc_cfg_pkg::NUM_PORTS; p++) begin : g_port
        localparam int SP = int'(noc_cfg_pkg::STRAIGHT_PORT[p]);

        // input side stays at the input port index
        assign ivc_sw_grant_o[p]    = grant[p].sw_grant;
        assign ivc_ovc_grant_o[p]   = grant[p].ovc_grant;
        assign ivc_reset_o[p]       = grant[p].ivc_reset;
        assign ivc_single_flit_o[p] = grant[p].single;
        assign ivc_granted_ovc_o[p] = grant[p].granted_ovc;

        // output side moves to the straight port with a one to one mapping
        assign ovc_is_allocated_o[SP]     = grant[p].ovc_alloc;
        assign ovc_is_released_o[SP]      = grant[p].ovc_release;
        assign buff_space_decreased_o[SP] = grant[p].credit_dec;
        assign ovc_single_flit_o[SP]      = grant[p].single;
        assign straight_sw_any[SP]        = |grant[p].sw_grant;
    end

    // flit reaches the straight output one cycle after the grant
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ssa_flit_wr_o <= '0;
        end else begin
            ssa_flit_wr_o <= straight_sw_any;
        end
    end

endmodule

`default_nettype wire

/* rtl/ssa_port_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module ssa_port_ctrl (
    input  noc_cfg_pkg::port_e      in_port_i,
    flit_info_if.ctrl               info,
    input  logic                    ss_port_busy_i,        // straight port already granted
    input  logic                    in_port_sw_granted_i,  // some ivc here won sa
    input  noc_cfg_pkg::vc_mask_t   ovc_avail_i,           // straight port ovcs
    input  noc_cfg_pkg::vc_mask_t   ovc_full_i,            // straight port ovcs
    input  noc_cfg_pkg::vc_mask_t   ivc_req_i,
    input  noc_cfg_pkg::vc_mask_t   ovc_is_assigned_i,
    input  flit_pkg::vc_grant_t     assigned_ovc_i,
    input  noc_cfg_pkg::port_e      buf_dest_i [noc_cfg_pkg::NUM_VCS],
    ssa_grant_if.ctrl               grant
);

    noc_cfg_pkg::port_e     straight_port;
    logic                   ssa_en;
    logic                   idle;
    logic                   is_hdr;
    logic                   is_tail;
    logic                   is_single;
    logic                   hdr_to_straight;
    logic                   credit_pre;
    logic                   alloc_pre;
    logic                   release_pre;
    noc_cfg_pkg::vc_mask_t  ovc_ready;
    noc_cfg_pkg::vc_mask_t  permit;
    noc_cfg_pkg::vc_mask_t  take;

    assign straight_port = noc_cfg_pkg::STRAIGHT_PORT[in_port_i];
    assign ssa_en = (straight_port != in_port_i);  // local maps to itself

    // nothing else switching through this input or into the straight port
    assign idle = ~(ss_port_busy_i | in_port_sw_granted_i);

    assign is_hdr    = (info.kind == flit_pkg::KIND_HDR) || (info.kind == flit_pkg::KIND_SINGLE);
    assign is_tail   = (info.kind == flit_pkg::KIND_TAIL) || (info.kind == flit_pkg::KIND_SINGLE);
    assign is_single = (info.kind == flit_pkg::KIND_SINGLE);
    assign hdr_to_straight = (info.dest == straight_port);

    // straight ovc readiness per vc
    always_comb begin
        for (int v = 0; v < noc_cfg_pkg::NUM_VCS; v++) begin
            if (ovc_is_assigned_i[v]) begin
                // body and tail need the packet to hold the same-numbered straight ovc
                ovc_ready[v] = (buf_dest_i[v] == straight_port) && assigned_ovc_i[v][v]
                               && !ovc_full_i[v];
            end else begin
                ovc_ready[v] = ovc_avail_i[v];
            end
        end
    end

    assign permit = (ssa_en && idle) ? (ovc_ready & ~ivc_req_i) : '0;
    assign take   = info.wr ? (info.vc & permit) : '0;

    // per-flit decisions before vc qualification
    assign credit_pre  = ~(is_hdr & ~hdr_to_straight);  // header going elsewhere is blocked
    assign alloc_pre   = is_hdr & hdr_to_straight;
    assign release_pre = is_single ? credit_pre : is_tail;

    assign grant.credit_dec  = credit_pre ? take : '0;
    assign grant.sw_grant    = grant.credit_dec;
    assign grant.ovc_grant   = alloc_pre ? take : '0;
    assign grant.ivc_reset   = release_pre ? take : '0;
    assign grant.single      = is_single ? grant.sw_grant : '0;
    // single-flit packets never hold the ovc
    assign grant.ovc_alloc   = grant.ovc_grant & ~grant.single;
    assign grant.ovc_release = grant.ivc_reset & ~grant.single;

    always_comb begin
        grant.granted_ovc = '0;
        for (int v = 0; v < noc_cfg_pkg::NUM_VCS; v++) begin
            grant.granted_ovc[v][v] = grant.ovc_grant[v];  // same vc number on straight port
        end
    end

endmodule

`default_nettype wire

/* rtl/flit_hdr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module flit_hdr_decoder (
    input  flit_pkg::flit_t     flit_i,
    input  logic                flit_wr_i,
    flit_info_if.decoder        info
);

    flit_pkg::flit_kind_e kind;

    // kind comes straight from the two flag bits
    always_comb begin
        unique case ({flit_i.hdr, flit_i.tail})
            2'b11:   kind = flit_pkg::KIND_SINGLE;
            2'b10:   kind = flit_pkg::KIND_HDR;
            2'b01:   kind = flit_pkg::KIND_TAIL;
            default: kind = flit_pkg::KIND_BODY;
        endcase
    end

    assign info.wr   = flit_wr_i;
    assign info.kind = kind;
    assign info.vc   = flit_i.vc;   // already one-hot on the link
    // dest field is only looked at for header flits
    assign info.dest = flit_i.dest;

endmodule

`default_nettype wire

/* rtl/ssa_grant_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface ssa_grant_if;

    // input side
    noc_cfg_pkg::vc_mask_t  sw_grant;
    noc_cfg_pkg::vc_mask_t  ovc_grant;
    noc_cfg_pkg::vc_mask_t  ivc_reset;
    flit_pkg::vc_grant_t    granted_ovc;
    // straight output side
    noc_cfg_pkg::vc_mask_t  credit_dec;
    noc_cfg_pkg::vc_mask_t  ovc_alloc;
    noc_cfg_pkg::vc_mask_t  ovc_release;
    // used on both sides
    noc_cfg_pkg::vc_mask_t  single;

    modport ctrl (
        output sw_grant, output ovc_grant, output ivc_reset, output granted_ovc,
        output credit_dec, output ovc_alloc, output ovc_release, output single
    );

    modport map (
        input sw_grant, input ovc_grant, input ivc_reset, input granted_ovc,
        input credit_dec, input ovc_alloc, input ovc_release, input single
    );

endinterface

`default_nettype wire

/* rtl/flit_info_if.sv */
`timescale 1ns/1ns
`default_nettype none

// decoded fields of the incoming flit that are valid while wr is high
interface flit_info_if;

    logic                   wr;
    flit_pkg::flit_kind_e   kind;
    noc_cfg_pkg::vc_mask_t  vc;
    noc_cfg_pkg::port_e     dest;   // only meaningful for header flits

    modport decoder (output wr, output kind, output vc, output dest);

    modport ctrl (input wr, input kind, input vc, input dest);

endinterface

`default_nettype wire

/* rtl/flit_pkg.sv */
`default_nettype none

package flit_pkg;

    localparam int FLIT_W = 32;
    localparam int PAYLOAD_W = FLIT_W - 2 - noc_cfg_pkg::NUM_VCS - noc_cfg_pkg::PORT_W;

    // field order from the msb is hdr, tail, vc, dest, payload
    typedef struct packed {
        logic                   hdr;
        logic                   tail;
        noc_cfg_pkg::vc_mask_t  vc;      // one-hot
        noc_cfg_pkg::port_e     dest;
        logic [PAYLOAD_W-1:0]   payload;
    } flit_t;

    // encoded as {hdr, tail}
    typedef enum logic [1:0] {
        KIND_BODY   = 2'b00,
        KIND_TAIL   = 2'b01,
        KIND_HDR    = 2'b10,
        KIND_SINGLE = 2'b11
    } flit_kind_e;

    // indexed [ivc][ovc] with a one-hot ovc number per input vc
    typedef logic [noc_cfg_pkg::NUM_VCS-1:0][noc_cfg_pkg::NUM_VCS-1:0] vc_grant_t;

endpackage

`default_nettype wire

/* rtl/noc_cfg_pkg.sv */
`default_nettype none

package noc_cfg_pkg;

    // geometry of the 5-port mesh router
    localparam int NUM_PORTS = 5;
    localparam int NUM_VCS   = 2;
    localparam int PORT_W    = 3;

    typedef enum logic [PORT_W-1:0] {
        PORT_LOCAL = 3'd0,
        PORT_EAST  = 3'd1,
        PORT_NORTH = 3'd2,
        PORT_WEST  = 3'd3,
        PORT_SOUTH = 3'd4
    } port_e;

    // one bit per vc
    typedef logic [NUM_VCS-1:0] vc_mask_t;

    // straight partner of each input port
    // local points at itself, which means no ssa path
    localparam port_e STRAIGHT_PORT [NUM_PORTS] = '{
        PORT_LOCAL, // local
        PORT_WEST,  // east  -> west
        PORT_SOUTH, // north -> south
        PORT_EAST,  // west  -> east
        PORT_NORTH  // south -> north
    };

endpackage

`default_nettype wire
